/* flist.f */
hw/jesd_pkg.sv
hw/jesd_lmfc.sv
hw/jesd_tx_link.sv
hw/jesd_rx_link.sv
hw/jesd_regs.sv
hw/jesd_loopback_top.sv
sim/jesd_link_assert.sv
sim/tb_jesd_loopback.sv

/* hw/jesd_lmfc.sv */
// sysref edge is taken against its one-cycle registered copy; count phase is unknown until sysref_seen
`timescale 1ns/1ps

module jesd_lmfc import jesd_pkg::*; (
  input  logic              device_clk,
  input  logic              rst,
  input  logic              sysref,
  output logic [LMFC_W-1:0] lmfc_count,
  output logic              sysref_seen
);

  logic sysref_q;     // sysref delayed one beat
  logic sysref_edge;

  assign sysref_edge = sysref & ~sysref_q;  // rising edge this cycle

  always_ff @(posedge device_clk) begin
    if (rst) begin
      sysref_q    <= 1'b0;
      lmfc_count  <= '0;
      sysref_seen <= 1'b0;
    end else begin
      sysref_q <= sysref;
      if (sysref_edge) begin
        lmfc_count  <= '0;    // realign multiframe
        sysref_seen <= 1'b1;  // sticky until reset
      end else if (lmfc_count == LMFC_W'(LMFC_BEATS - 1)) begin
        lmfc_count <= '0;     // multiframe wrap
      end else begin
        lmfc_count <= lmfc_count + 1'b1;
      end
    end
  end

endmodule

/* hw/jesd_loopback_top.sv */
// everything on device_clk; lanes and sync are looped outside, sample source has no back-pressure
`timescale 1ns/1ps

module jesd_loopback_top import jesd_pkg::*; (
  input  logic      device_clk,
  input  logic      rst,
  input  logic      sysref,
  input  axil_req_t axil,
  output axil_rsp_t axil_rsp,
  input  samples_t  tx_samples,
  output logic      tx_ready,
  output lanes_t    tx_lanes,
  input  lanes_t    rx_lanes,
  input  logic      tx_sync,
  output logic      rx_sync,
  output samples_t  rx_samples,
  output logic      rx_valid
);

  link_ctrl_t        ctrl;           // from registers to both links
  link_status_t      status;
  logic [LMFC_W-1:0] lmfc_count;
  logic              sysref_seen;
  logic              tx_data_phase;
  logic [31:0]       rx_beats;

  assign status = '{rx_beats: rx_beats, sysref_seen: sysref_seen,
                    tx_data_phase: tx_data_phase, rx_sync: rx_sync};

  // **************************************************************************
  // management and timing
  // **************************************************************************

  jesd_regs i_regs (
    .device_clk (device_clk),
    .rst        (rst),
    .axil       (axil),
    .axil_rsp   (axil_rsp),
    .ctrl       (ctrl),
    .status     (status)
  );

  jesd_lmfc i_lmfc (
    .device_clk  (device_clk),
    .rst         (rst),
    .sysref      (sysref),
    .lmfc_count  (lmfc_count),
    .sysref_seen (sysref_seen)
  );

  // **************************************************************************
  // link layer pair
  // **************************************************************************

  jesd_tx_link i_tx (
    .device_clk    (device_clk),
    .rst           (rst),
    .ctrl          (ctrl),
    .tx_sync       (tx_sync),
    .lmfc_count    (lmfc_count),
    .sysref_seen   (sysref_seen),
    .tx_samples    (tx_samples),
    .tx_ready      (tx_ready),
    .tx_lanes      (tx_lanes),
    .tx_data_phase (tx_data_phase)
  );

  jesd_rx_link i_rx (
    .device_clk (device_clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .rx_lanes   (rx_lanes),
    .rx_sync    (rx_sync),
    .rx_samples (rx_samples),
    .rx_valid   (rx_valid),
    .rx_beats   (rx_beats)
  );

endmodule

/* hw/jesd_pkg.sv */
// single device_clk domain, no 8b/10b, ILAS or deskew; lane words are four octets plus K flags
package jesd_pkg;

  // **************************************************************************
  // link geometry
  // **************************************************************************

  localparam int NUM_LANES       = 4;                      // lanes per link
  localparam int OCTETS_PER_BEAT = 4;                      // octets per lane per clock
  localparam int LMFC_BEATS      = 16;                     // beats per local multiframe
  localparam int LMFC_W          = $clog2(LMFC_BEATS);     // lmfc counter width
  localparam int CGS_COUNT       = 4;                      // all-K beats to pass CGS
  localparam int CGS_W           = $clog2(CGS_COUNT + 1);  // saturating counter width
  localparam int SCR_W           = 15;                     // 1 + x^14 + x^15 state
  localparam logic [7:0] K28_5   = 8'hbc;                  // code group sync character

  // register map, byte addresses
  localparam int AXIL_AW = 8;
  localparam logic [AXIL_AW-1:0] REG_CTRL     = 8'h00;   // rw
  localparam logic [AXIL_AW-1:0] REG_STATUS   = 8'h04;   // ro
  localparam logic [AXIL_AW-1:0] REG_RX_BEATS = 8'h08;   // ro
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // **************************************************************************
  // lane and sample types
  // **************************************************************************

  // same 32 bits, octets for the link, samples for the converter
  typedef union packed {
    logic [OCTETS_PER_BEAT-1:0][7:0] octet;  // octet[3] goes out first
    logic [1:0][15:0]                sample;
  } lane_word_u;

  typedef struct packed {
    lane_word_u                 data;
    logic [OCTETS_PER_BEAT-1:0] charisk;    // one flag per octet
  } lane_beat_t;

  typedef lane_beat_t [NUM_LANES-1:0] lanes_t;    // lane bus
  typedef lane_word_u [NUM_LANES-1:0] samples_t;  // converter data bus

  // beat sent during code group sync
  localparam lane_beat_t K_BEAT = {{OCTETS_PER_BEAT{K28_5}}, {OCTETS_PER_BEAT{1'b1}}};

  // **************************************************************************
  // control, status and AXI4-Lite
  // **************************************************************************

  typedef struct packed {
    logic scr_en;   // bit 1
    logic link_en;  // bit 0
  } link_ctrl_t;

  typedef struct packed {
    logic [31:0] rx_beats;       // valid rx beats since reset
    logic        sysref_seen;    // status bit 2
    logic        tx_data_phase;  // status bit 1
    logic        rx_sync;        // status bit 0
  } link_status_t;

  typedef struct packed {
    logic [AXIL_AW-1:0] awaddr;
    logic               awvalid;
    logic [31:0]        wdata;
    logic [3:0]         wstrb;
    logic               wvalid;
    logic               bready;
    logic [AXIL_AW-1:0] araddr;
    logic               arvalid;
    logic               rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

endpackage

/* hw/jesd_regs.sv */
// one write and one read outstanding; full byte address decode, anything outside the map gets SLVERR
`timescale 1ns/1ps

module jesd_regs import jesd_pkg::*; (
  input  logic         device_clk,
  input  logic         rst,
  input  axil_req_t    axil,
  output axil_rsp_t    axil_rsp,
  output link_ctrl_t   ctrl,
  input  link_status_t status
);

  logic               aw_got;   // address phase done
  logic               w_got;    // data phase done
  logic [AXIL_AW-1:0] wr_addr;
  logic [31:0]        wr_data;
  logic [3:0]         wr_strb;
  logic               wr_err;
  logic [31:0]        rd_data;
  logic               rd_err;

  // **************************************************************************
  // address decode
  // **************************************************************************

  assign wr_err = !(wr_addr == REG_CTRL || wr_addr == REG_STATUS || wr_addr == REG_RX_BEATS);

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (axil.araddr)
      REG_CTRL:     rd_data = 32'(ctrl);
      REG_STATUS:   rd_data = 32'({status.sysref_seen, status.tx_data_phase, status.rx_sync});
      REG_RX_BEATS: rd_data = status.rx_beats;
      default:      rd_err  = 1'b1;  // rdata stays zero
    endcase
  end

  // **************************************************************************
  // write and read channels
  // **************************************************************************

  always_ff @(posedge device_clk) begin
    if (rst) begin
      axil_rsp <= '0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      ctrl     <= '0;
    end else begin
      // ready pulses for one cycle per accepted phase
      axil_rsp.awready <= axil.awvalid & ~axil_rsp.awready & ~aw_got & ~axil_rsp.bvalid;
      axil_rsp.wready  <= axil.wvalid & ~axil_rsp.wready & ~w_got & ~axil_rsp.bvalid;
      axil_rsp.arready <= axil.arvalid & ~axil_rsp.arready & ~axil_rsp.rvalid;

      if (axil.awvalid && axil_rsp.awready) begin
        aw_got  <= 1'b1;
        wr_addr <= axil.awaddr;
      end
      if (axil.wvalid && axil_rsp.wready) begin
        w_got   <= 1'b1;
        wr_data <= axil.wdata;
        wr_strb <= axil.wstrb;
      end

      // both phases in, commit and respond
      if (aw_got && w_got && !axil_rsp.bvalid) begin
        aw_got          <= 1'b0;
        w_got           <= 1'b0;
        axil_rsp.bvalid <= 1'b1;
        axil_rsp.bresp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
        if (wr_addr == REG_CTRL && wr_strb[0]) begin
          ctrl <= link_ctrl_t'(wr_data[1:0]);  // status writes dropped
        end
      end else if (axil_rsp.bvalid && axil.bready) begin
        axil_rsp.bvalid <= 1'b0;
      end

      if (axil.arvalid && axil_rsp.arready) begin
        axil_rsp.rvalid <= 1'b1;   // one cycle after accept
        axil_rsp.rdata  <= rd_data;
        axil_rsp.rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
      end else if (axil_rsp.rvalid && axil.rready) begin
        axil_rsp.rvalid <= 1'b0;
      end
    end
  end

endmodule

/* hw/jesd_rx_link.sv */
// lanes assumed aligned with no skew; data starts on the first all-data beat after sync, no ILAS check
`timescale 1ns/1ps

module jesd_rx_link import jesd_pkg::*; (
  input  logic        device_clk,
  input  logic        rst,
  input  link_ctrl_t  ctrl,
  input  lanes_t      rx_lanes,
  output logic        rx_sync,
  output samples_t    rx_samples,
  output logic        rx_valid,
  output logic [31:0] rx_beats
);

  // **************************************************************************
  // descrambler, state fed from received bits
  // **************************************************************************

  function automatic lane_word_u descramble(input lane_word_u din,
                                            input logic [SCR_W-1:0] st_in);
    lane_word_u       dout;
    logic [SCR_W-1:0] st;
    st   = st_in;
    dout = '0;
    for (int o = OCTETS_PER_BEAT - 1; o >= 0; o--) begin
      for (int b = 7; b >= 0; b--) begin
        dout.octet[o][b] = din.octet[o][b] ^ st[SCR_W-1] ^ st[SCR_W-2];
        st               = {st[SCR_W-2:0], din.octet[o][b]};  // self-synchronizing
      end
    end
    return dout;
  endfunction

  logic [NUM_LANES-1:0][CGS_W-1:0] cgs_cnt;      // consecutive K beats, saturating
  logic [NUM_LANES-1:0][CGS_W-1:0] cgs_next;
  logic [NUM_LANES-1:0]            is_k;         // lane carries a full K beat
  logic [NUM_LANES-1:0]            no_k;         // lane carries pure data
  logic [NUM_LANES-1:0]            cgs_done;
  logic [NUM_LANES-1:0][SCR_W-1:0] descr_state;  // last 15 received bits per lane
  samples_t                        descr_word;
  logic                            in_data;
  logic                            data_beat;    // beat delivered next cycle
  logic                            k_in_data;    // link lost

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      is_k[l] = (rx_lanes[l] == K_BEAT);
      no_k[l] = (rx_lanes[l].charisk == '0);
      if (!is_k[l]) begin
        cgs_next[l] = '0;                       // any other beat restarts
      end else if (cgs_cnt[l] == CGS_W'(CGS_COUNT)) begin
        cgs_next[l] = cgs_cnt[l];
      end else begin
        cgs_next[l] = cgs_cnt[l] + 1'b1;
      end
      cgs_done[l]   = (cgs_next[l] == CGS_W'(CGS_COUNT));
      descr_word[l] = descramble(rx_lanes[l].data, in_data ? descr_state[l] : '0);
    end
  end

  assign data_beat = ctrl.link_en & rx_sync & (&no_k);
  assign k_in_data = in_data & ~(&no_k);

  // **************************************************************************
  // code group sync and data phase
  // **************************************************************************

  always_ff @(posedge device_clk) begin
    if (rst) begin
      cgs_cnt  <= '0;
      rx_sync  <= 1'b0;
      in_data  <= 1'b0;
      rx_valid <= 1'b0;
      rx_beats <= '0;
    end else if (!ctrl.link_en) begin
      cgs_cnt  <= '0;        // rx_beats kept across disable
      rx_sync  <= 1'b0;
      in_data  <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      cgs_cnt  <= cgs_next;  // data beats clear it too
      rx_valid <= data_beat;
      if (data_beat) begin
        rx_beats <= rx_beats + 1'b1;  // wraps
      end
      if (k_in_data) begin
        in_data <= 1'b0;     // resync
        rx_sync <= 1'b0;
      end else begin
        if (data_beat) begin
          in_data <= 1'b1;
        end
        if (&cgs_done) begin
          rx_sync <= 1'b1;
        end
      end
    end
  end

  // sample path
  always_ff @(posedge device_clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (data_beat) begin
        descr_state[l] <= rx_lanes[l].data[SCR_W-1:0];
        rx_samples[l]  <= ctrl.scr_en ? descr_word[l] : rx_lanes[l].data;
      end
    end
  end

endmodule

/* hw/jesd_tx_link.sv */
// no ILAS; data starts on lmfc 0 once sync is high, and sample source must supply a word whenever tx_ready
`timescale 1ns/1ps

module jesd_tx_link import jesd_pkg::*; (
  input  logic              device_clk,
  input  logic              rst,
  input  link_ctrl_t        ctrl,
  input  logic              tx_sync,
  input  logic [LMFC_W-1:0] lmfc_count,
  input  logic              sysref_seen,
  input  samples_t          tx_samples,
  output logic              tx_ready,
  output lanes_t            tx_lanes,
  output logic              tx_data_phase
);

  // **************************************************************************
  // scrambler, 1 + x^14 + x^15, msb of octet 3 first
  // **************************************************************************

  function automatic lane_word_u scramble(input lane_word_u din, input logic [SCR_W-1:0] st_in);
    lane_word_u       dout;
    logic [SCR_W-1:0] st;
    logic             s;
    st   = st_in;
    dout = '0;
    for (int o = OCTETS_PER_BEAT - 1; o >= 0; o--) begin
      for (int b = 7; b >= 0; b--) begin
        s                = din.octet[o][b] ^ st[SCR_W-1] ^ st[SCR_W-2];  // taps 15, 14
        dout.octet[o][b] = s;
        st               = {st[SCR_W-2:0], s};  // feedback from output
      end
    end
    return dout;
  endfunction

  logic                            go;          // link allowed to leave CGS
  logic                            start;       // first data beat, on lmfc 0
  logic                            wait_lmfc;   // sync seen, waiting for boundary
  logic                            data_phase;
  logic [NUM_LANES-1:0][SCR_W-1:0] scr_state;   // last 15 scrambled bits per lane
  samples_t                        scr_word;

  assign go            = ctrl.link_en & tx_sync & sysref_seen;
  assign start         = wait_lmfc & go & (lmfc_count == '0);
  assign tx_ready      = data_phase | start;  // drops the cycle after go falls
  assign tx_data_phase = data_phase;

  // state is zero on the first data beat
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      scr_word[l] = scramble(tx_samples[l], data_phase ? scr_state[l] : '0);
    end
  end

  // **************************************************************************
  // CGS -> wait lmfc -> data
  // **************************************************************************

  always_ff @(posedge device_clk) begin
    if (rst) begin
      wait_lmfc  <= 1'b0;
      data_phase <= 1'b0;
    end else if (!go) begin
      wait_lmfc  <= 1'b0;   // back to CGS
      data_phase <= 1'b0;
    end else if (start) begin
      wait_lmfc  <= 1'b0;
      data_phase <= 1'b1;
    end else if (!data_phase) begin
      wait_lmfc <= 1'b1;    // sync seen, hold for boundary
    end
  end

  // lane output, one cycle after accept
  always_ff @(posedge device_clk) begin
    if (rst) begin
      tx_lanes <= {NUM_LANES{K_BEAT}};
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (tx_ready) begin
          tx_lanes[l].data    <= ctrl.scr_en ? scr_word[l] : tx_samples[l];
          tx_lanes[l].charisk <= '0;
        end else begin
          tx_lanes[l] <= K_BEAT;  // code group sync
        end
      end
    end
  end

  always_ff @(posedge device_clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (tx_ready) begin
        scr_state[l] <= scr_word[l][SCR_W-1:0];  // newest bit in lsb
      end
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the loopback testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_jesd_loopback -o tb_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
grep -q "^Test passed$" sim.log && echo "PASS" && exit 0 \
  || { echo "FAIL, see sim.log"; exit 1; }

/* sim/jesd_link_assert.sv */
// bound into the loopback top level; checks are skipped while rst is high
`timescale 1ns/1ps

module jesd_link_assert import jesd_pkg::*; (
  input logic              device_clk,
  input logic              rst,
  input logic              tx_ready,
  input logic [LMFC_W-1:0] lmfc_count,
  input logic              rx_valid,
  input logic              rx_sync,
  input axil_req_t         axil,
  input axil_rsp_t         axil_rsp
);

  // data phase only opens on a multiframe boundary
  a_tx_start: assert property (@(posedge device_clk) disable iff (rst)
    $rose(tx_ready) |-> lmfc_count == '0)
    else $error("tx_ready rose off lmfc boundary");

  a_valid_sync: assert property (@(posedge device_clk) disable iff (rst)
    rx_valid |-> rx_sync)
    else $error("rx_valid without rx_sync");

  a_bvalid_hold: assert property (@(posedge device_clk) disable iff (rst)
    axil_rsp.bvalid && !axil.bready |=> axil_rsp.bvalid)
    else $error("bvalid dropped before bready");

endmodule

bind jesd_loopback_top jesd_link_assert u_link_assert (
  .device_clk (device_clk),
  .rst        (rst),
  .tx_ready   (tx_ready),
  .lmfc_count (lmfc_count),
  .rx_valid   (rx_valid),
  .rx_sync    (rx_sync),
  .axil       (axil),
  .axil_rsp   (axil_rsp)
);

/* sim/tb_jesd_loopback.sv */
// loopback testbench; lanes and sync are wired back externally, stops at the first mismatch
`timescale 1ns/1ps

module tb_jesd_loopback import jesd_pkg::*; ();

  localparam int NUM_WORDS = 100;  // words checked per data phase

  logic       device_clk;
  logic       rst;
  logic       sysref;
  axil_req_t  axil;
  axil_rsp_t  axil_rsp;
  samples_t   tx_samples;
  samples_t   rx_samples;
  lanes_t     tx_lanes;
  lanes_t     rx_lanes;
  logic       tx_ready;
  logic       tx_sync;
  logic       rx_sync;
  logic       rx_valid;

  integer            seed = 43360;
  logic [LMFC_W-1:0] m_lmfc;           // model multiframe counter
  logic              m_sysref_q;
  logic              m_seen;
  samples_t          sent_q[$];        // accepted words awaiting rx
  int                rx_count;         // words received since reset
  int                err_count;
  logic              scr_on;           // shadow of ctrl.scr_en
  logic [31:0]       rd_val;
  logic [1:0]        resp;

  assign rx_lanes = tx_lanes;  // lane loopback
  assign tx_sync  = rx_sync;

  jesd_loopback_top dut (
    .device_clk (device_clk),
    .rst        (rst),
    .sysref     (sysref),
    .axil       (axil),
    .axil_rsp   (axil_rsp),
    .tx_samples (tx_samples),
    .tx_ready   (tx_ready),
    .tx_lanes   (tx_lanes),
    .rx_lanes   (rx_lanes),
    .tx_sync    (tx_sync),
    .rx_sync    (rx_sync),
    .rx_samples (rx_samples),
    .rx_valid   (rx_valid)
  );

  // ****************************************************************************
  // reference model and compare tasks
  // ****************************************************************************

  // 1 + x^14 + x^15, bit 31 sent first, output bits fed back
  function automatic lane_word_u scramble_word(input lane_word_u din,
                                               inout logic [SCR_W-1:0] st);
    lane_word_u dout;
    logic       bit_out;
    for (int i = 31; i >= 0; i--) begin
      bit_out = din[i] ^ st[14] ^ st[13];  // x^15 and x^14 terms
      dout[i] = bit_out;
      st      = {st[13:0], bit_out};
    end
    return dout;
  endfunction

  task automatic stop_fail(input string msg);
    err_count++;
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_beat(input string name, input lane_beat_t got, input lane_beat_t exp);
    if (got !== exp) begin
      stop_fail($sformatf("ERR %s got %h exp %h", name, got, exp));
    end
  endtask

  task automatic check_samples(input string name, input samples_t got, input samples_t exp);
    if (got !== exp) begin
      stop_fail($sformatf("ERR %s got %h exp %h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_fail($sformatf("ERR %s got %h exp %h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      stop_fail($sformatf("ERR %s got %h exp %h", name, got, exp));
    end
  endtask

  // ****************************************************************************
  // AXI4-Lite access
  // ****************************************************************************

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] bresp);
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(posedge device_clk);
    axil.awaddr  <= addr;
    axil.awvalid <= 1'b1;
    axil.wdata   <= data;
    axil.wstrb   <= 4'hf;
    axil.wvalid  <= 1'b1;
    axil.bready  <= 1'b1;
    while (!(aw_done && w_done)) begin
      @(negedge device_clk);
      if (axil_rsp.awready) aw_done = 1'b1;
      if (axil_rsp.wready) w_done = 1'b1;
      @(posedge device_clk);
      if (aw_done) axil.awvalid <= 1'b0;
      if (w_done) axil.wvalid <= 1'b0;
    end
    do @(negedge device_clk); while (!axil_rsp.bvalid);
    bresp = axil_rsp.bresp;
    @(posedge device_clk);
    axil.bready <= 1'b0;        // bvalid drops on this edge
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] rresp);
    @(posedge device_clk);
    axil.araddr  <= addr;
    axil.arvalid <= 1'b1;
    axil.rready  <= 1'b1;
    do @(negedge device_clk); while (!axil_rsp.arready);
    @(posedge device_clk);
    axil.arvalid <= 1'b0;
    do @(negedge device_clk); while (!axil_rsp.rvalid);
    data  = axil_rsp.rdata;
    rresp = axil_rsp.rresp;
    @(posedge device_clk);
    axil.rready <= 1'b0;
  endtask

  // ****************************************************************************
  // clock, sysref, stimulus, model lmfc
  // ****************************************************************************

  initial begin
    device_clk = 1'b0;
    forever #5 device_clk = ~device_clk;
  end

  initial begin
    rst        = 1'b1;
    sysref     = 1'b0;
    axil       = '0;
    tx_samples = '0;
    repeat (10) @(posedge device_clk);
    rst <= 1'b0;
    repeat (20) @(posedge device_clk);
    forever begin
      sysref <= 1'b1;                                // one-cycle pulse
      @(posedge device_clk);
      sysref <= 1'b0;
      repeat (LMFC_BEATS * 4 - 1) @(posedge device_clk);
    end
  end

  // fresh random word every cycle, taken whenever tx_ready
  always @(posedge device_clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      tx_samples[l] <= $random(seed);
    end
  end

  // edge in cycle n gives count 0 in n+1
  always @(posedge device_clk) begin
    if (rst) begin
      m_sysref_q <= 1'b0;
      m_lmfc     <= '0;
      m_seen     <= 1'b0;
    end else begin
      m_sysref_q <= sysref;
      if (sysref && !m_sysref_q) begin
        m_lmfc <= '0;
        m_seen <= 1'b1;
      end else begin
        m_lmfc <= m_lmfc + 1'b1;  // wraps at LMFC_BEATS
      end
    end
  end

  // ****************************************************************************
  // comparing process, sampled on the falling edge
  // ****************************************************************************

  initial begin : compare
    logic                            prev_ready;
    logic                            prev2_ready;
    samples_t                        prev_samples;
    logic [NUM_LANES-1:0][SCR_W-1:0] m_state;   // model scrambler per lane
    lane_beat_t                      exp_beat;
    lane_word_u                      scr;
    prev_ready  = 1'b0;
    prev2_ready = 1'b0;
    rx_count    = 0;
    forever begin
      @(negedge device_clk);
      if (rst) continue;
      for (int l = 0; l < NUM_LANES; l++) begin
        if (prev_ready) begin
          if (!prev2_ready) m_state[l] = '0;  // cleared on data entry
          scr              = scramble_word(prev_samples[l], m_state[l]);
          exp_beat.data    = scr_on ? scr : prev_samples[l];
          exp_beat.charisk = '0;
        end else begin
          exp_beat = K_BEAT;  // code group sync
        end
        check_beat($sformatf("tx_lanes[%0d]", l), tx_lanes[l], exp_beat);
      end
      if (tx_ready && !prev_ready) begin
        check_word("lmfc_count at tx_ready rise", 32'(m_lmfc), 32'd0);
      end
      if (rx_valid) begin
        if (sent_q.size() == 0) begin
          stop_fail("rx_valid with no word outstanding");
        end
        check_samples("rx_samples", rx_samples, sent_q.pop_front());
        rx_count++;
      end
      if (tx_ready) sent_q.push_back(tx_samples);
      prev2_ready  = prev_ready;
      prev_ready   = tx_ready;
      prev_samples = tx_samples;
    end
  end

  initial begin : watchdog
    #((2 * NUM_WORDS + 40 * LMFC_BEATS) * 10 + 5000);
    stop_fail("watchdog expired before the test sequence finished");
  end

  // ****************************************************************************
  // test sequence
  // ****************************************************************************

  task automatic wait_words(input int target);
    while (rx_count < target) @(posedge device_clk);
  endtask

  task automatic link_down_flush();
    while (rx_sync || tx_ready) @(negedge device_clk);
    repeat (4) @(posedge device_clk);
    sent_q.delete();               // words cut off by the disable
  endtask

  initial begin : main
    err_count = 0;
    scr_on    = 1'b0;
    @(negedge device_clk);
    while (rst) @(negedge device_clk);
    check_word("tx_ready", 32'(tx_ready), 32'd0);
    check_word("rx_valid", 32'(rx_valid), 32'd0);
    check_word("rx_sync", 32'(rx_sync), 32'd0);
    axil_read(REG_STATUS, rd_val, resp);
    check_word("status", rd_val, 32'h0);
    while (!m_seen) @(posedge device_clk);
    repeat (2) @(posedge device_clk);
    axil_read(REG_STATUS, rd_val, resp);
    check_word("status", rd_val, 32'h4);

    // bring-up, plain data
    axil_write(REG_CTRL, 32'h1, resp);
    check_resp("bresp", resp, RESP_OKAY);
    while (!tx_ready) @(negedge device_clk);
    axil_read(REG_STATUS, rd_val, resp);
    check_word("status", rd_val, 32'h7);
    wait_words(NUM_WORDS);

    // toggle with scrambling
    axil_write(REG_CTRL, 32'h0, resp);
    link_down_flush();
    scr_on = 1'b1;
    axil_write(REG_CTRL, 32'h3, resp);
    wait_words(rx_count + NUM_WORDS);

    // disable, last beat still scrambled
    axil_write(REG_CTRL, 32'h2, resp);
    link_down_flush();
    axil_read(REG_RX_BEATS, rd_val, resp);
    check_word("rx_beats", rd_val, 32'(rx_count));

    // register errors
    axil_read(8'h0c, rd_val, resp);
    check_resp("rresp", resp, RESP_SLVERR);
    check_word("rdata", rd_val, 32'h0);
    axil_write(8'h0c, 32'h1, resp);
    check_resp("bresp", resp, RESP_SLVERR);
    axil_write(REG_STATUS, 32'hff, resp);
    check_resp("bresp", resp, RESP_OKAY);
    axil_read(REG_STATUS, rd_val, resp);
    check_word("status", rd_val, 32'h4);  // only sysref_seen left
    axil_read(REG_CTRL, rd_val, resp);
    check_resp("rresp", resp, RESP_OKAY);
    check_word("ctrl", rd_val, 32'h2);    // untouched by the stray writes

    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
